// ==== verilog/muldiv_pkg.sv ====
// shared types for the iterative multiply/divide unit
// every rtl file refers to these by scoped name
package muldiv_pkg;

  // operand width, the top level hands it down as WIDTH
  parameter int data_width = 32;

  // operation codes carried in the request
  typedef enum logic [1:0] {
    op_mul  = 2'd0,
    op_div  = 2'd1,
    op_divu = 2'd2
  } muldiv_op_e;

  // request payload, op plus two operands
  typedef struct packed {
    muldiv_op_e            op;
    logic [data_width-1:0] a;
    logic [data_width-1:0] b;
  } muldiv_req_t;

  // upper half is remainder or high product, lower half quotient or low product
  typedef struct packed {
    logic [2*data_width-1:0] result;
  } muldiv_resp_t;

  // shared by the divider control and the multiplier
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } iter_state_e;

endpackage

// ==== verilog/int_div_dpath.sv ====
// datapath of the restoring shift-and-subtract divider
// all enables and mux selects come from int_div_ctrl
`timescale 1ns/1ps

module int_div_dpath #(
  parameter int WIDTH = muldiv_pkg::data_width
) (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_req_t  req,
  input  logic                     is_signed,
  input  logic                     a_en,
  input  logic                     b_en,
  input  logic                     a_mux_sel,
  input  logic                     sub_mux_sel,
  input  logic                     cntr_mux_sel,
  input  logic                     sign_en,
  input  logic                     div_sign_sel,
  input  logic                     rem_sign_sel,
  output logic                     sub_msb,
  output logic                     counter_is_zero,
  output logic                     div_sign,
  output logic                     rem_sign,
  output muldiv_pkg::muldiv_resp_t resp
);

  localparam int cnt_w = $clog2(WIDTH);

  // remainder in the upper half, quotient in the lower, one guard bit on top
  logic [2*WIDTH:0] a_reg;
  // divisor sits aligned with the remainder half
  logic [2*WIDTH:0] b_reg;
  logic [cnt_w-1:0] counter_reg;
  logic             div_sign_reg;
  logic             rem_sign_reg;

  // --------------------
  // operand stage
  // --------------------

  logic [WIDTH-1:0] a_mag;
  logic [WIDTH-1:0] b_mag;
  logic [WIDTH-1:0] a_in;
  logic [WIDTH-1:0] b_in;

  // two's complement magnitude of each operand
  assign a_mag = req.a[WIDTH-1] ? (~req.a + 1'b1) : req.a;
  assign b_mag = req.b[WIDTH-1] ? (~req.b + 1'b1) : req.b;

  // divu keeps the raw bits
  assign a_in = is_signed ? a_mag : req.a;
  assign b_in = is_signed ? b_mag : req.b;

  // --------------------
  // iteration
  // --------------------

  logic [2*WIDTH:0] a_initial;
  logic [2*WIDTH:0] b_initial;
  logic [2*WIDTH:0] a_shift;
  logic [2*WIDTH:0] sub_out;
  logic [2*WIDTH:0] sub_keep;
  logic [2*WIDTH:0] sub_mux_out;
  logic [2*WIDTH:0] a_mux_out;
  logic [cnt_w-1:0] counter_next;

  assign a_initial = {{(WIDTH + 1){1'b0}}, a_in};
  assign b_initial = {1'b0, b_in, {WIDTH{1'b0}}};

  // shift remainder/quotient left, then trial subtract
  assign a_shift = {a_reg[2*WIDTH-1:0], 1'b0};
  assign sub_out = a_shift - b_reg;
  // negative difference tells control to restore
  assign sub_msb = sub_out[2*WIDTH];

  // keep the difference and set the quotient bit
  assign sub_keep = {sub_out[2*WIDTH:1], 1'b1};
  // restore path is the plain shift, quotient bit stays 0
  assign sub_mux_out = sub_mux_sel ? a_shift : sub_keep;
  assign a_mux_out = a_mux_sel ? sub_mux_out : a_initial;

  // counts down from WIDTH-1 during calc
  assign counter_next = cntr_mux_sel ? (counter_reg - 1'b1) : cnt_w'(WIDTH - 1);
  assign counter_is_zero = (counter_reg == '0);

  always_ff @(posedge clk) begin
    if (reset) begin
      counter_reg <= '0;
    end else begin
      counter_reg <= counter_next;
    end
  end

  always_ff @(posedge clk) begin
    if (a_en) begin
      a_reg <= a_mux_out;
    end
    if (b_en) begin
      b_reg <= b_initial;
    end
    // signs only matter for div, divu leaves both clear
    if (sign_en) begin
      div_sign_reg <= is_signed & (req.a[WIDTH-1] ^ req.b[WIDTH-1]);
      rem_sign_reg <= is_signed & req.a[WIDTH-1];
    end
  end

  assign div_sign = div_sign_reg;
  assign rem_sign = rem_sign_reg;

  // --------------------
  // result stage
  // --------------------

  logic [WIDTH-1:0] quotient;
  logic [WIDTH-1:0] remainder;

  assign quotient = a_reg[WIDTH-1:0];
  assign remainder = a_reg[2*WIDTH-1:WIDTH];

  // remainder follows the dividend, quotient negates on sign mismatch
  assign resp.result = {rem_sign_sel ? (~remainder + 1'b1) : remainder,
                        div_sign_sel ? (~quotient + 1'b1) : quotient};

endmodule

// ==== verilog/int_div_ctrl.sv ====
// control FSM of the iterative divider
// sequences int_div_dpath through idle, calc and done
`timescale 1ns/1ps

module int_div_ctrl (
  input  logic                   clk,
  input  logic                   reset,
  input  muldiv_pkg::muldiv_op_e op,
  input  logic                   req_val,
  output logic                   req_rdy,
  output logic                   resp_val,
  input  logic                   resp_rdy,
  input  logic                   sub_msb,
  input  logic                   counter_is_zero,
  input  logic                   div_sign,
  input  logic                   rem_sign,
  output logic                   is_signed,
  output logic                   a_en,
  output logic                   b_en,
  output logic                   a_mux_sel,
  output logic                   sub_mux_sel,
  output logic                   cntr_mux_sel,
  output logic                   sign_en,
  output logic                   div_sign_sel,
  output logic                   rem_sign_sel
);

  muldiv_pkg::iter_state_e state;
  muldiv_pkg::iter_state_e state_next;
  logic                    accept;
  logic                    send;

  // request taken in idle, response handed off in done
  assign accept = (state == muldiv_pkg::st_idle) && req_val;
  assign send = (state == muldiv_pkg::st_done) && resp_rdy;

  // only div treats operands as signed
  assign is_signed = (op == muldiv_pkg::op_div);

  // --------------------
  // state register
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::st_idle;
    end else begin
      state <= state_next;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      muldiv_pkg::st_idle: begin
        if (accept) begin
          state_next = muldiv_pkg::st_calc;
        end
      end
      // last iteration runs with the counter at zero
      muldiv_pkg::st_calc: begin
        if (counter_is_zero) begin
          state_next = muldiv_pkg::st_done;
        end
      end
      // hold result until the consumer takes it
      muldiv_pkg::st_done: begin
        if (send) begin
          state_next = muldiv_pkg::st_idle;
        end
      end
      default: begin
        state_next = muldiv_pkg::st_idle;
      end
    endcase
  end

  // --------------------
  // control outputs
  // --------------------

  always_comb begin
    req_rdy = 1'b0;
    resp_val = 1'b0;
    a_en = 1'b0;
    b_en = 1'b0;
    a_mux_sel = 1'b0;
    sub_mux_sel = 1'b0;
    cntr_mux_sel = 1'b0;
    sign_en = 1'b0;
    div_sign_sel = 1'b0;
    rem_sign_sel = 1'b0;
    case (state)
      // load operands and signs on the accept edge, counter reloads
      muldiv_pkg::st_idle: begin
        req_rdy = 1'b1;
        a_en = accept;
        b_en = accept;
        sign_en = accept;
      end
      // one shift-subtract step per cycle
      muldiv_pkg::st_calc: begin
        a_en = 1'b1;
        a_mux_sel = 1'b1;
        sub_mux_sel = sub_msb;
        cntr_mux_sel = 1'b1;
      end
      // stored signs fix up the result
      muldiv_pkg::st_done: begin
        resp_val = 1'b1;
        div_sign_sel = div_sign;
        rem_sign_sel = rem_sign;
      end
      default: begin
        req_rdy = 1'b0;
      end
    endcase
  end

endmodule

// ==== verilog/int_mul_iterative.sv ====
// iterative shift-and-add multiplier, one multiplier bit per cycle
// signed 64-bit product, same val/rdy ports as the divider
`timescale 1ns/1ps

module int_mul_iterative #(
  parameter int WIDTH = muldiv_pkg::data_width
) (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_req_t  req,
  input  logic                     req_val,
  output logic                     req_rdy,
  output muldiv_pkg::muldiv_resp_t resp,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  localparam int cnt_w = $clog2(WIDTH);

  muldiv_pkg::iter_state_e state;
  muldiv_pkg::iter_state_e state_next;
  logic [cnt_w-1:0]        counter_reg;
  logic                    accept;
  logic                    send;

  // multiplicand widened so it can shift left
  logic [2*WIDTH-1:0] a_reg;
  logic [WIDTH-1:0]   b_reg;
  logic [2*WIDTH-1:0] prod_reg;
  logic               neg_reg;
  logic [WIDTH-1:0]   a_mag;
  logic [WIDTH-1:0]   b_mag;

  assign accept = (state == muldiv_pkg::st_idle) && req_val;
  assign send = (state == muldiv_pkg::st_done) && resp_rdy;

  assign a_mag = req.a[WIDTH-1] ? (~req.a + 1'b1) : req.a;
  assign b_mag = req.b[WIDTH-1] ? (~req.b + 1'b1) : req.b;

  // --------------------
  // FSM and counter
  // --------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= muldiv_pkg::st_idle;
      counter_reg <= '0;
    end else begin
      state <= state_next;
      if (accept) begin
        counter_reg <= cnt_w'(WIDTH - 1);
      end else if (state == muldiv_pkg::st_calc) begin
        counter_reg <= counter_reg - 1'b1;
      end
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      muldiv_pkg::st_idle: begin
        if (accept) begin
          state_next = muldiv_pkg::st_calc;
        end
      end
      muldiv_pkg::st_calc: begin
        if (counter_reg == '0) begin
          state_next = muldiv_pkg::st_done;
        end
      end
      muldiv_pkg::st_done: begin
        if (send) begin
          state_next = muldiv_pkg::st_idle;
        end
      end
      default: begin
        state_next = muldiv_pkg::st_idle;
      end
    endcase
  end

  // --------------------
  // datapath
  // --------------------

  always_ff @(posedge clk) begin
    if (accept) begin
      a_reg <= {{WIDTH{1'b0}}, a_mag};
      b_reg <= b_mag;
      prod_reg <= '0;
      neg_reg <= req.a[WIDTH-1] ^ req.b[WIDTH-1];
    end else if (state == muldiv_pkg::st_calc) begin
      // accumulate when the current multiplier bit is set
      if (b_reg[0]) begin
        prod_reg <= prod_reg + a_reg;
      end
      a_reg <= {a_reg[2*WIDTH-2:0], 1'b0};
      b_reg <= {1'b0, b_reg[WIDTH-1:1]};
    end
  end

  assign req_rdy = (state == muldiv_pkg::st_idle);
  assign resp_val = (state == muldiv_pkg::st_done);
  // restore the sign of the product
  assign resp.result = neg_reg ? (~prod_reg + 1'b1) : prod_reg;

endmodule

// ==== verilog/muldiv_dispatch.sv ====
// steers each request to the multiplier or the divider
// one operation in flight, so responses return in request order
`timescale 1ns/1ps

module muldiv_dispatch (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_req_t  req,
  input  logic                     req_val,
  output logic                     req_rdy,
  output muldiv_pkg::muldiv_resp_t resp,
  output logic                     resp_val,
  input  logic                     resp_rdy,
  output logic                     div_req_val,
  input  logic                     div_req_rdy,
  input  muldiv_pkg::muldiv_resp_t div_resp,
  input  logic                     div_resp_val,
  output logic                     div_resp_rdy,
  output logic                     mul_req_val,
  input  logic                     mul_req_rdy,
  input  muldiv_pkg::muldiv_resp_t mul_resp,
  input  logic                     mul_resp_val,
  output logic                     mul_resp_rdy
);

  logic busy;
  // set when the multiplier owns the operation in flight
  logic owner_mul;
  logic to_mul;

  // div and divu both go to the divider
  assign to_mul = (req.op == muldiv_pkg::op_mul);

  // request side, blocked while an operation is in flight
  assign req_rdy = !busy && (to_mul ? mul_req_rdy : div_req_rdy);
  assign mul_req_val = req_val && !busy && to_mul;
  assign div_req_val = req_val && !busy && !to_mul;

  // response side follows the owner
  assign resp = owner_mul ? mul_resp : div_resp;
  assign resp_val = busy && (owner_mul ? mul_resp_val : div_resp_val);
  assign mul_resp_rdy = busy && owner_mul && resp_rdy;
  assign div_resp_rdy = busy && !owner_mul && resp_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      busy <= 1'b0;
      owner_mul <= 1'b0;
    end else if (req_val && req_rdy) begin
      busy <= 1'b1;
      owner_mul <= to_mul;
    end else if (resp_val && resp_rdy) begin
      busy <= 1'b0;
    end
  end

endmodule

// ==== verilog/muldiv_unit.sv ====
// top level of the iterative multiply/divide unit
// val/rdy request in, val/rdy 64-bit response out
`timescale 1ns/1ps

module muldiv_unit #(
  parameter int WIDTH = muldiv_pkg::data_width
) (
  input  logic                     clk,
  input  logic                     reset,
  input  muldiv_pkg::muldiv_req_t  req,
  input  logic                     req_val,
  output logic                     req_rdy,
  output muldiv_pkg::muldiv_resp_t resp,
  output logic                     resp_val,
  input  logic                     resp_rdy
);

  // unit handshakes
  logic                     div_req_val;
  logic                     div_req_rdy;
  muldiv_pkg::muldiv_resp_t div_resp;
  logic                     div_resp_val;
  logic                     div_resp_rdy;
  logic                     mul_req_val;
  logic                     mul_req_rdy;
  muldiv_pkg::muldiv_resp_t mul_resp;
  logic                     mul_resp_val;
  logic                     mul_resp_rdy;

  // divider control to datapath
  logic is_signed;
  logic a_en;
  logic b_en;
  logic a_mux_sel;
  logic sub_mux_sel;
  logic cntr_mux_sel;
  logic sign_en;
  logic div_sign_sel;
  logic rem_sign_sel;
  logic sub_msb;
  logic counter_is_zero;
  logic div_sign;
  logic rem_sign;

  muldiv_dispatch dispatch_i (
    .clk          (clk),
    .reset        (reset),
    .req          (req),
    .req_val      (req_val),
    .req_rdy      (req_rdy),
    .resp         (resp),
    .resp_val     (resp_val),
    .resp_rdy     (resp_rdy),
    .div_req_val  (div_req_val),
    .div_req_rdy  (div_req_rdy),
    .div_resp     (div_resp),
    .div_resp_val (div_resp_val),
    .div_resp_rdy (div_resp_rdy),
    .mul_req_val  (mul_req_val),
    .mul_req_rdy  (mul_req_rdy),
    .mul_resp     (mul_resp),
    .mul_resp_val (mul_resp_val),
    .mul_resp_rdy (mul_resp_rdy)
  );

  // both units see the same request payload
  int_div_dpath #(
    .WIDTH (WIDTH)
  ) div_dpath_i (
    .clk             (clk),
    .reset           (reset),
    .req             (req),
    .is_signed       (is_signed),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .sub_mux_sel     (sub_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .div_sign_sel    (div_sign_sel),
    .rem_sign_sel    (rem_sign_sel),
    .sub_msb         (sub_msb),
    .counter_is_zero (counter_is_zero),
    .div_sign        (div_sign),
    .rem_sign        (rem_sign),
    .resp            (div_resp)
  );

  int_div_ctrl div_ctrl_i (
    .clk             (clk),
    .reset           (reset),
    .op              (req.op),
    .req_val         (div_req_val),
    .req_rdy         (div_req_rdy),
    .resp_val        (div_resp_val),
    .resp_rdy        (div_resp_rdy),
    .sub_msb         (sub_msb),
    .counter_is_zero (counter_is_zero),
    .div_sign        (div_sign),
    .rem_sign        (rem_sign),
    .is_signed       (is_signed),
    .a_en            (a_en),
    .b_en            (b_en),
    .a_mux_sel       (a_mux_sel),
    .sub_mux_sel     (sub_mux_sel),
    .cntr_mux_sel    (cntr_mux_sel),
    .sign_en         (sign_en),
    .div_sign_sel    (div_sign_sel),
    .rem_sign_sel    (rem_sign_sel)
  );

  int_mul_iterative #(
    .WIDTH (WIDTH)
  ) mul_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp     (mul_resp),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy)
  );

endmodule

// ==== test/muldiv_checker.sv ====
// concurrent assertions on the dispatcher request and response handshakes
// bound into muldiv_dispatch by the testbench
`timescale 1ns/1ps

module muldiv_checker (
  input logic                     clk,
  input logic                     reset,
  input logic                     req_val,
  input logic                     req_rdy,
  input muldiv_pkg::muldiv_resp_t resp,
  input logic                     resp_val,
  input logic                     resp_rdy
);

  // tally of failed assertions, read by the testbench at the end
  int fail_count = 0;

  // operation in flight as seen from the port handshakes alone
  logic in_flight;

  always_ff @(posedge clk) begin
    if (reset) begin
      in_flight <= 1'b0;
    end else if (req_val && req_rdy) begin
      in_flight <= 1'b1;
    end else if (resp_val && resp_rdy) begin
      in_flight <= 1'b0;
    end
  end

  // idle and ready as soon as reset drops
  reset_release: assert property (@(posedge clk) $fell(reset) |-> req_rdy && !resp_val)
    else begin
      $error("req_rdy low or resp_val high right after reset");
      fail_count++;
    end

  // no new request while one is in flight
  busy_blocks_req: assert property (@(posedge clk) disable iff (reset) in_flight |-> !req_rdy)
    else begin
      $error("req_rdy high while an operation is in flight");
      fail_count++;
    end

  // fixed latency of 33 edges from request to response
  resp_latency: assert property (@(posedge clk) disable iff (reset)
    (req_val && req_rdy) |-> ##33 $rose(resp_val))
    else begin
      $error("resp_val did not rise 33 cycles after the request");
      fail_count++;
    end

  // back-pressure holds the response and keeps the request side closed
  resp_hold: assert property (@(posedge clk) disable iff (reset)
    (resp_val && !resp_rdy) |=> resp_val && $stable(resp) && !req_rdy)
    else begin
      $error("response dropped or changed under back-pressure");
      fail_count++;
    end

  // a response only comes from an accepted request
  resp_owned: assert property (@(posedge clk) disable iff (reset) resp_val |-> in_flight)
    else begin
      $error("resp_val high with nothing in flight");
      fail_count++;
    end

endmodule

// ==== test/muldiv_monitor.sv ====
// watches the DUT ports, queues the model result on each request
// and compares it with the response, also checks response latency
`timescale 1ns/1ps

module muldiv_monitor (
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                req_val,
  input  logic                                req_rdy,
  input  muldiv_pkg::muldiv_resp_t            resp,
  input  logic                                resp_val,
  input  logic                                resp_rdy,
  input  logic [2*muldiv_pkg::data_width-1:0] model_exp,
  output int                                  error_count,
  output int                                  resp_count
);

  localparam int dw = muldiv_pkg::data_width;
  localparam int latency_exp = 33;

  // expected results in request order
  logic [2*dw-1:0] expected_q[$];
  logic [2*dw-1:0] expected;
  int              errors = 0;
  int              responses = 0;
  int              since_req = 0;
  logic            in_flight = 1'b0;
  logic            resp_val_d = 1'b0;

  assign error_count = errors;
  assign resp_count = responses;

  // inputs change on the falling edge, so values here are settled
  always @(posedge clk) begin
    if (reset) begin
      in_flight = 1'b0;
      resp_val_d = 1'b0;
    end else begin
      if (in_flight) begin
        since_req++;
      end
      // --------------------
      // latency on rising resp_val
      // --------------------
      if (resp_val && !resp_val_d) begin
        if (!in_flight) begin
          $display("response valid raised with no request in flight");
          errors++;
        end else if (since_req != latency_exp) begin
          $display("response valid raised %0d cycles after the request, not %0d",
                   since_req, latency_exp);
          errors++;
        end
      end
      // --------------------
      // result compare
      // --------------------
      if (resp_val && resp_rdy) begin
        responses++;
        in_flight = 1'b0;
        if (expected_q.size() == 0) begin
          $display("response accepted while no request was pending");
          errors++;
        end else begin
          expected = expected_q.pop_front();
          if (resp.result !== expected) begin
            $display("ERROR resp.result expected %h actual %h", expected, resp.result);
            errors++;
          end
        end
      end
      // new operation starts counting from its handshake edge
      if (req_val && req_rdy) begin
        expected_q.push_back(model_exp);
        in_flight = 1'b1;
        since_req = 0;
      end
      resp_val_d = resp_val;
    end
  end

endmodule

// ==== test/muldiv_tb.sv ====
// testbench for the iterative multiply/divide unit
// LFSR driven requests and back-pressure, model results go to the monitor
`timescale 1ns/1ps

module muldiv_tb;

  localparam int dw = muldiv_pkg::data_width;
  localparam int num_ops = 300;
  // 33 cycles of latency plus the response edge
  localparam int op_cycles = 34;
  // request gap plus response stall, generous per operation
  localparam int stall_allowance = 12;
  localparam int timeout_cycles = num_ops * (op_cycles + stall_allowance) + 100;

  logic                     clk;
  logic                     reset;
  muldiv_pkg::muldiv_req_t  req;
  logic                     req_val;
  logic                     req_rdy;
  muldiv_pkg::muldiv_resp_t resp;
  logic                     resp_val;
  logic                     resp_rdy;

  logic [2*dw-1:0] model_exp;
  logic [31:0]     lfsr_state;
  logic            req_taken;
  int              stall_left;
  int              mon_errors;
  int              resp_count;
  int              cycle_count;

  muldiv_unit #(
    .WIDTH (dw)
  ) muldiv_unit_i (
    .clk      (clk),
    .reset    (reset),
    .req      (req),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  muldiv_monitor monitor_i (
    .clk         (clk),
    .reset       (reset),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp        (resp),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy),
    .model_exp   (model_exp),
    .error_count (mon_errors),
    .resp_count  (resp_count)
  );

  bind muldiv_dispatch muldiv_checker checker_i (
    .clk      (clk),
    .reset    (reset),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .resp     (resp),
    .resp_val (resp_val),
    .resp_rdy (resp_rdy)
  );

  always #10 clk = ~clk;

  // handshake seen on the rising edge, acted on at the next falling edge
  always @(posedge clk) begin
    req_taken <= req_val && req_rdy;
  end

  // --------------------
  // random source
  // --------------------

  // x^32 + x^22 + x^2 + x + 1, new bit enters at the bottom
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int k = 0; k < n; k++) begin
      lfsr_state = lfsr_step(lfsr_state);
      v = {v[30:0], lfsr_state[0]};
    end
  endtask

  // corner values show up often, small values give long quotients
  task automatic pick_operand(output logic [dw-1:0] x);
    logic [31:0] sel;
    take_bits(3, sel);
    case (sel)
      32'd0: x = '0;
      32'd1: x = '1;
      32'd2: x = {1'b1, {(dw - 1){1'b0}}};
      32'd3: take_bits(5, x);
      default: take_bits(dw, x);
    endcase
  endtask

  // --------------------
  // reference model
  // --------------------

  // divide works on magnitudes and applies signs afterwards
  // div by zero gives all ones
  function automatic logic [2*dw-1:0] model_result(input muldiv_pkg::muldiv_req_t r);
    logic [dw-1:0]   mag_a;
    logic [dw-1:0]   mag_b;
    logic [dw-1:0]   q;
    logic [dw-1:0]   rm;
    logic [2*dw-1:0] prod;
    mag_a = r.a[dw-1] ? (~r.a + 1'b1) : r.a;
    mag_b = r.b[dw-1] ? (~r.b + 1'b1) : r.b;
    if (r.op == muldiv_pkg::op_mul) begin
      // sign-extended operands, the low 64 bits hold the signed product
      prod = {{dw{r.a[dw-1]}}, r.a} * {{dw{r.b[dw-1]}}, r.b};
      return prod;
    end
    // divu works on the raw bits
    if (r.op == muldiv_pkg::op_divu) begin
      mag_a = r.a;
      mag_b = r.b;
    end
    if (mag_b == '0) begin
      q = '1;
      rm = mag_a;
    end else begin
      q = mag_a / mag_b;
      rm = mag_a % mag_b;
    end
    if (r.op == muldiv_pkg::op_div) begin
      if (r.a[dw-1] ^ r.b[dw-1]) begin
        q = ~q + 1'b1;
      end
      if (r.a[dw-1]) begin
        rm = ~rm + 1'b1;
      end
    end
    return {rm, q};
  endfunction

  // --------------------
  // stimulus
  // --------------------

  task automatic offer_request();
    logic [31:0]             v;
    muldiv_pkg::muldiv_req_t r;
    take_bits(2, v);
    case (v)
      32'd1: r.op = muldiv_pkg::op_div;
      32'd2: r.op = muldiv_pkg::op_divu;
      default: r.op = muldiv_pkg::op_mul;
    endcase
    pick_operand(r.a);
    pick_operand(r.b);
    req = r;
    model_exp = model_result(r);
    req_val = 1'b1;
  endtask

  // mostly ready, now and then a stall of up to 8 cycles
  task automatic drive_resp_rdy();
    logic [31:0] v;
    if (stall_left > 0) begin
      resp_rdy = 1'b0;
      stall_left--;
    end else begin
      take_bits(3, v);
      if (v == 32'd0) begin
        take_bits(3, v);
        stall_left = v;
        resp_rdy = 1'b0;
      end else begin
        resp_rdy = 1'b1;
      end
    end
  endtask

  initial begin
    logic [31:0] v;
    int          issued;
    int          gap;
    int          assert_fails;
    clk = 1'b0;
    reset = 1'b1;
    req = '0;
    req_val = 1'b0;
    resp_rdy = 1'b0;
    model_exp = '0;
    lfsr_state = 32'hf8;
    stall_left = 0;
    issued = 0;
    gap = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    // one request at a time, random idle gap after each accept
    while (resp_count < num_ops) begin
      @(negedge clk);
      drive_resp_rdy();
      if (req_val) begin
        if (req_taken) begin
          req_val = 1'b0;
          issued++;
          take_bits(2, v);
          gap = v;
        end
      end else if (gap > 0) begin
        gap--;
      end else if (issued < num_ops) begin
        offer_request();
      end
    end
    repeat (2) @(negedge clk);
    assert_fails = muldiv_unit_i.dispatch_i.checker_i.fail_count;
    $display("responses %0d of %0d, monitor errors %0d, assertion failures %0d",
             resp_count, num_ops, mon_errors, assert_fails);
    if (mon_errors == 0 && assert_fails == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

  // run limit, scaled from the number of operations
  initial begin
    cycle_count = 0;
    while (cycle_count < timeout_cycles) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("timeout after %0d cycles with %0d of %0d responses received",
             cycle_count, resp_count, num_ops);
    $display("Regression failed");
    $finish;
  end

endmodule

// ==== muldiv.f ====
verilog/muldiv_pkg.sv
verilog/int_div_dpath.sv
verilog/int_div_ctrl.sv
verilog/int_mul_iterative.sv
verilog/muldiv_dispatch.sv
verilog/muldiv_unit.sv
test/muldiv_checker.sv
test/muldiv_monitor.sv
test/muldiv_tb.sv

// ==== Makefile ====
VERILATOR = verilator
FLAGS     = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = muldiv_tb
FILELIST  = muldiv.f
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Regression failed" $(LOG) || ! grep -q "Regression passed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
